/* rtl/archPkg.sv */
package archPkg;

        typedef logic [15:0] word_t;
        typedef logic [3:0] regNum_t;

        localparam int regCount = 10;

        // Architectural register numbers
        localparam regNum_t regR0 = 4'd0;
        localparam regNum_t regR1 = 4'd1;
        localparam regNum_t regR2 = 4'd2;
        localparam regNum_t regR3 = 4'd3;
        localparam regNum_t regR4 = 4'd4;
        localparam regNum_t regR5 = 4'd5;
        localparam regNum_t regR6 = 4'd6;
        localparam regNum_t regR7 = 4'd7;
        localparam regNum_t regPc = 4'd8;
        localparam regNum_t regSp = 4'd9;

        typedef struct packed {
                regNum_t src1;
                regNum_t src2;
                logic [7:0] spare;      // Unused by operand fetch
        } regForm_t;

        typedef struct packed {
                regNum_t src1;
                logic signed [11:0] imm;
        } immForm_t;

        // src1 sits in the top nibble in both forms
        typedef union packed {
                regForm_t regForm;
                immForm_t immForm;
        } instrWord_u;

endpackage

/* rtl/pipePkg.sv */
package pipePkg;

        // Issue stage to operand fetch
        typedef struct packed {
                logic isImm;
                archPkg::instrWord_u instr;
        } issueReq_t;

        // In-flight result from an older pipeline stage
        typedef struct packed {
                logic writes;
                archPkg::regNum_t dst;
                archPkg::word_t value;
        } pendWrite_t;

        typedef struct packed {
                logic valid;
                archPkg::regNum_t dst;
                archPkg::word_t value;
        } retireWrite_t;

        // Operand fetch to execute stage
        typedef struct packed {
                archPkg::word_t opA;
                archPkg::word_t opB;
                logic fwdA;             // opA came from an in-flight result
                logic fwdB;
        } operandBundle_t;

endpackage

/* rtl/issueIn.sv */
module issueIn (
        input  logic clk,
        input  logic rstN,
        input  logic issueReq,
        input  pipePkg::issueReq_t issueData,
        output logic issueAck,
        input  logic busy,
        output logic take,
        output pipePkg::issueReq_t item
);
        import pipePkg::*;

        typedef enum logic [1:0] {
                stIdle,
                stHold,
                stWaitLow
        } ackState_t;

        ackState_t state;
        logic slotFull;
        issueReq_t slot;
        logic capture;

        // Ack side and slot side run independently
        assign capture = (state == stIdle) && issueReq && !slotFull;
        assign take = slotFull && !busy;
        assign item = slot;
        assign issueAck = (state == stWaitLow);

        always_ff @(posedge clk)
        begin
                if (!rstN)
                begin
                        state <= stIdle;
                        slotFull <= 1'b0;
                end
                else
                begin
                        case (state)
                                stIdle:
                                begin
                                        if (capture)
                                                state <= stHold;
                                end
                                stHold: state <= stWaitLow;     // Ack rises next cycle
                                stWaitLow:
                                begin
                                        if (!issueReq)
                                                state <= stIdle;
                                end
                                default: state <= stIdle;
                        endcase

                        if (capture)
                                slotFull <= 1'b1;
                        else if (take)
                                slotFull <= 1'b0;
                end
        end

        always_ff @(posedge clk)
        begin
                if (capture)
                        slot <= issueData;
        end

endmodule

/* rtl/regFile.sv */
module regFile (
        input  logic clk,
        input  logic rstN,
        input  pipePkg::retireWrite_t retire,
        input  archPkg::regNum_t rdNumA,
        input  archPkg::regNum_t rdNumB,
        output archPkg::word_t rdValA,
        output archPkg::word_t rdValB
);
        import archPkg::*;
        import pipePkg::*;

        word_t regs [regCount];
        logic wrHit;

        assign wrHit = retire.valid && (retire.dst < regCount);

        always_ff @(posedge clk)
        begin
                if (!rstN)
                begin
                        for (int i = 0; i < regCount; i++)
                                regs[i] <= '0;
                end
                else if (wrHit)
                begin
                        regs[retire.dst] <= retire.value;
                end
        end

        // Same-cycle retire passes straight through
        function automatic word_t readPort(regNum_t num);
                if (num >= regCount)
                        return '0;      // Out of range reads as zero
                if (wrHit && (retire.dst == num))
                        return retire.value;
                return regs[num];
        endfunction

        always_comb
        begin
                rdValA = readPort(rdNumA);
                rdValB = readPort(rdNumB);
        end

endmodule

/* rtl/operandForward.sv */
module operandForward (
        input  logic clk,
        input  logic rstN,
        input  logic take,
        input  pipePkg::issueReq_t item,
        input  pipePkg::pendWrite_t pendOld,
        input  pipePkg::pendWrite_t pendNew,
        input  logic fwdEnable,
        output archPkg::regNum_t rdNumA,
        output archPkg::regNum_t rdNumB,
        input  archPkg::word_t rdValA,
        input  archPkg::word_t rdValB,
        input  logic full,
        output logic busy,
        output logic load,
        output pipePkg::operandBundle_t bundle
);
        import archPkg::*;
        import pipePkg::*;

        word_t immExt;
        logic newA;
        logic oldA;
        logic newB;
        logic oldB;
        operandBundle_t nextBundle;

        function automatic logic hits(pendWrite_t p, regNum_t num);
                return p.writes && (p.dst == num);
        endfunction

        // Decode the instruction word
        assign rdNumA = item.instr.regForm.src1;        // Same nibble in both forms
        assign rdNumB = item.instr.regForm.src2;
        assign immExt = {{4{item.instr.immForm.imm[11]}}, item.instr.immForm.imm};

        assign newA = fwdEnable && hits(pendNew, rdNumA);
        assign oldA = fwdEnable && hits(pendOld, rdNumA);
        assign newB = fwdEnable && hits(pendNew, rdNumB);
        assign oldB = fwdEnable && hits(pendOld, rdNumB);

        // Younger result wins, then older, then register file
        always_comb
        begin
                nextBundle.opA = newA ? pendNew.value : (oldA ? pendOld.value : rdValA);
                nextBundle.fwdA = newA || oldA;

                if (item.isImm)
                begin
                        nextBundle.opB = immExt;
                        nextBundle.fwdB = 1'b0;         // Immediate is never forwarded
                end
                else
                begin
                        nextBundle.opB = newB ? pendNew.value
                                              : (oldB ? pendOld.value : rdValB);
                        nextBundle.fwdB = newB || oldB;
                end
        end

        always_ff @(posedge clk)
        begin
                if (!rstN)
                        load <= 1'b0;
                else
                        load <= take;
        end

        always_ff @(posedge clk)
        begin
                if (take)
                        bundle <= nextBundle;
        end

        assign busy = full;

endmodule

/* rtl/operandOut.sv */
module operandOut (
        input  logic clk,
        input  logic rstN,
        input  logic load,
        input  pipePkg::operandBundle_t bundle,
        output logic full,
        output logic opReq,
        output pipePkg::operandBundle_t opData,
        input  logic opAck
);
        import pipePkg::*;

        operandBundle_t hold;

        always_ff @(posedge clk)
        begin
                if (!rstN)
                begin
                        full <= 1'b0;
                        opReq <= 1'b0;
                end
                else
                begin
                        if (load)
                        begin
                                full <= 1'b1;
                                opReq <= 1'b1;
                        end
                        else if (opReq && opAck)
                        begin
                                opReq <= 1'b0;
                        end
                        else if (full && !opReq && !opAck)
                        begin
                                full <= 1'b0;   // Handshake back to idle
                        end
                end
        end

        // Stays stable until the slot frees up
        always_ff @(posedge clk)
        begin
                if (load)
                        hold <= bundle;
        end

        assign opData = hold;

endmodule

/* rtl/operandFetchTop.sv */
module operandFetchTop (
        input  logic clk,
        input  logic rstN,
        input  logic issueReq,
        input  pipePkg::issueReq_t issueData,
        output logic issueAck,
        input  pipePkg::pendWrite_t pendOld,
        input  pipePkg::pendWrite_t pendNew,
        input  logic fwdEnable,
        input  pipePkg::retireWrite_t retire,
        output logic opReq,
        output pipePkg::operandBundle_t opData,
        input  logic opAck
);
        import archPkg::*;
        import pipePkg::*;

        logic take;
        logic busy;
        logic load;
        logic full;
        issueReq_t item;
        operandBundle_t bundle;
        regNum_t rdNumA;
        regNum_t rdNumB;
        word_t rdValA;
        word_t rdValB;

        issueIn u_issueIn (
                .clk       (clk),
                .rstN      (rstN),
                .issueReq  (issueReq),
                .issueData (issueData),
                .issueAck  (issueAck),
                .busy      (busy),
                .take      (take),
                .item      (item)
        );

        regFile u_regFile (
                .clk    (clk),
                .rstN   (rstN),
                .retire (retire),
                .rdNumA (rdNumA),
                .rdNumB (rdNumB),
                .rdValA (rdValA),
                .rdValB (rdValB)
        );

        operandForward u_operandForward (
                .clk       (clk),
                .rstN      (rstN),
                .take      (take),
                .item      (item),
                .pendOld   (pendOld),
                .pendNew   (pendNew),
                .fwdEnable (fwdEnable),
                .rdNumA    (rdNumA),
                .rdNumB    (rdNumB),
                .rdValA    (rdValA),
                .rdValB    (rdValB),
                .full      (full),
                .busy      (busy),
                .load      (load),
                .bundle    (bundle)
        );

        operandOut u_operandOut (
                .clk    (clk),
                .rstN   (rstN),
                .load   (load),
                .bundle (bundle),
                .full   (full),
                .opReq  (opReq),
                .opData (opData),
                .opAck  (opAck)
        );

endmodule

/* sim/fetchModel.svh */
`ifndef fetchModelSvh
`define fetchModelSvh

// Shadow copy of the architectural registers
word_t shadow [regCount];

function automatic void applyRetire(retireWrite_t r);
        if (r.valid && int'(r.dst) < regCount)
                shadow[r.dst] = r.value;
endfunction

function automatic word_t readShadow(regNum_t num);
        if (int'(num) >= regCount)
                return '0;      // Unmapped numbers read as zero
        return shadow[num];
endfunction

// Younger in-flight result first, then older, then the registers
function automatic void resolveSource(input regNum_t num, input pendWrite_t pOld,
                                      input pendWrite_t pNew, input logic fwdEn,
                                      output word_t val, output logic fwd);
        val = readShadow(num);
        fwd = 1'b0;
        if (fwdEn && pNew.writes && pNew.dst == num)
        begin
                val = pNew.value;
                fwd = 1'b1;
        end
        else if (fwdEn && pOld.writes && pOld.dst == num)
        begin
                val = pOld.value;
                fwd = 1'b1;
        end
endfunction

function automatic operandBundle_t expectBundle(issueReq_t req, pendWrite_t pOld,
                                                pendWrite_t pNew, logic fwdEn);
        operandBundle_t b;
        int immVal;
        if (req.isImm)
        begin
                resolveSource(req.instr.immForm.src1, pOld, pNew, fwdEn, b.opA, b.fwdA);
                immVal = int'($signed(req.instr.immForm.imm));
                b.opB = word_t'(immVal);
                b.fwdB = 1'b0;
        end
        else
        begin
                resolveSource(req.instr.regForm.src1, pOld, pNew, fwdEn, b.opA, b.fwdA);
                resolveSource(req.instr.regForm.src2, pOld, pNew, fwdEn, b.opB, b.fwdB);
        end
        return b;
endfunction

task automatic checkBundle(input operandBundle_t exp, input operandBundle_t act,
                           input string what);
        if (act !== exp)
        begin
                $display("ERR %0t: %s expected opA=%h opB=%h fwd=%b%b got opA=%h opB=%h fwd=%b%b",
                         $time, what, exp.opA, exp.opB, exp.fwdA, exp.fwdB,
                         act.opA, act.opB, act.fwdA, act.fwdB);
                $display("Finished with errors");
                $fatal(1, "operand bundle mismatch");
        end
endtask

task automatic checkWord(input word_t exp, input word_t act, input string what);
        if (act !== exp)
        begin
                $display("ERR %0t: %s expected %h got %h", $time, what, exp, act);
                $display("Finished with errors");
                $fatal(1, "word mismatch");
        end
endtask

task automatic checkFlag(input logic exp, input logic act, input string what);
        if (act !== exp)
        begin
                $display("ERR %0t: %s expected %b got %b", $time, what, exp, act);
                $display("Finished with errors");
                $fatal(1, "flag mismatch");
        end
endtask

`endif

/* sim/fetchTb.sv */
module fetchTb;
        timeunit 1ns;
        timeprecision 100ps;

        import archPkg::*;
        import pipePkg::*;

        localparam int numTrans = 400;
        localparam int cycleLimit = numTrans * 12;

        logic clk;
        logic rstN;
        logic issueReq;
        issueReq_t issueData;
        logic issueAck;
        pendWrite_t pendOld;
        pendWrite_t pendNew;
        logic fwdEnable;
        retireWrite_t retire;
        logic opReq;
        operandBundle_t opData;
        logic opAck;

        integer seed = 32'h3e27_0627;
        int cycles = 0;
        operandBundle_t expQ [$];       // Expected bundles in issue order

        `include "fetchModel.svh"

        operandFetchTop u_dut (
                .clk       (clk),
                .rstN      (rstN),
                .issueReq  (issueReq),
                .issueData (issueData),
                .issueAck  (issueAck),
                .pendOld   (pendOld),
                .pendNew   (pendNew),
                .fwdEnable (fwdEnable),
                .retire    (retire),
                .opReq     (opReq),
                .opData    (opData),
                .opAck     (opAck)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= cycleLimit)
                begin
                        $display("Timeout: handshake stalled, run passed %0d cycles", cycles);
                        $display("Finished with errors");
                        $fatal(1, "timeout");
                end
        end

        function automatic int randBelow(int n);
                return int'($unsigned($random(seed)) % n);
        endfunction

        function automatic regNum_t randReg();
                return regNum_t'(randBelow(regCount));
        endfunction

        function automatic word_t randWord();
                return word_t'($random(seed));
        endfunction

        function automatic pendWrite_t randomPend();
                pendWrite_t p;
                p.writes = randBelow(2) == 1;
                p.dst = randReg();
                p.value = randWord();
                return p;
        endfunction

        function automatic issueReq_t regFormReq(regNum_t a, regNum_t b);
                issueReq_t r;
                r.isImm = 1'b0;
                r.instr.regForm.src1 = a;
                r.instr.regForm.src2 = b;
                r.instr.regForm.spare = 8'($random(seed));
                return r;
        endfunction

        function automatic issueReq_t immFormReq(regNum_t a);
                issueReq_t r;
                r.isImm = 1'b1;
                r.instr.immForm.src1 = a;
                r.instr.immForm.imm = 12'($random(seed));
                return r;
        endfunction

        // Inputs change 2 ns after the rising edge
        task automatic nextCycle();
                @(posedge clk);
                #2;
        endtask

        task automatic retireOne(input regNum_t dst, input word_t value);
                retire.valid = 1'b1;
                retire.dst = dst;
                retire.value = value;
                applyRetire(retire);
                nextCycle();
                retire.valid = 1'b0;
        endtask

        task automatic issueHandshake(input issueReq_t req, input operandBundle_t exp);
                issueData = req;
                issueReq = 1'b1;
                while (!issueAck)
                        nextCycle();
                expQ.push_back(exp);    // Bundle now owed downstream
                issueReq = 1'b0;
                while (issueAck)
                        nextCycle();
        endtask

        task automatic executeHandshake(output operandBundle_t got);
                operandBundle_t exp;
                int delay;
                while (!opReq)
                        nextCycle();
                if (expQ.size() == 0)
                begin
                        $display("opReq rose before any issue request was acknowledged");
                        $display("Finished with errors");
                        $fatal(1, "unexpected bundle");
                end
                exp = expQ.pop_front();
                got = opData;
                checkBundle(exp, got, "opData");
                delay = randBelow(4);
                repeat (delay)
                begin
                        nextCycle();
                        checkFlag(1'b1, opReq, "opReq before ack");
                        checkBundle(exp, opData, "opData held");
                end
                opAck = 1'b1;
                while (opReq)
                begin
                        nextCycle();
                        checkBundle(exp, opData, "opData held");
                end
                opAck = 1'b0;
        endtask

        // Side inputs stay still while the transaction is in flight
        task automatic runTrans(input issueReq_t req, input pendWrite_t pOld,
                                input pendWrite_t pNew, input logic fwdEn,
                                input retireWrite_t ret, output operandBundle_t got);
                operandBundle_t exp;
                pendOld = pOld;
                pendNew = pNew;
                fwdEnable = fwdEn;
                retire = ret;
                applyRetire(ret);
                exp = expectBundle(req, pOld, pNew, fwdEn);
                fork
                        issueHandshake(req, exp);
                        executeHandshake(got);
                join
                retire.valid = 1'b0;
                pendOld.writes = 1'b0;
                pendNew.writes = 1'b0;
        endtask

        initial
        begin
                issueReq_t req;
                pendWrite_t pOld;
                pendWrite_t pNew;
                retireWrite_t ret;
                operandBundle_t got;
                regNum_t a;
                regNum_t b;
                regNum_t probeDst;
                logic fwdEn;
                logic probeDue;
                int kind;

                rstN = 1'b0;
                issueReq = 1'b0;
                issueData = '0;
                pendOld = '0;
                pendNew = '0;
                fwdEnable = 1'b0;
                retire = '0;
                opAck = 1'b0;
                probeDue = 1'b0;
                probeDst = '0;
                foreach (shadow[r])
                        shadow[r] = '0;
                repeat (2) @(posedge clk);
                #2;
                rstN = 1'b1;
                checkFlag(1'b0, issueAck, "issueAck after reset");
                checkFlag(1'b0, opReq, "opReq after reset");

                for (int r = 0; r < regCount; r++)
                        retireOne(regNum_t'(r), randWord());

                for (int i = 0; i < numTrans; i++)
                begin
                        kind = probeDue ? 6 : randBelow(6);
                        a = randReg();
                        b = randReg();
                        req = regFormReq(a, b);
                        pOld = randomPend();
                        pNew = randomPend();
                        fwdEn = 1'b1;
                        ret = '0;
                        case (kind)
                                0:
                                begin
                                        fwdEn = 1'b0;
                                        if (randBelow(2) == 1)
                                                retireOne(randReg(), randWord());
                                end
                                1:
                                begin
                                        pOld.writes = 1'b1;
                                        pOld.dst = a;
                                        pNew.writes = 1'b1;
                                        pNew.dst = b;
                                        if (randBelow(4) == 0)
                                        begin
                                                req = regFormReq(regPc, regSp);  // PC/SP swap
                                                pOld.dst = regSp;
                                                pNew.dst = regPc;
                                        end
                                end
                                2:
                                begin
                                        pOld.writes = 1'b1;
                                        pOld.dst = a;
                                        pNew.dst = a;   // Same target, writes may be low
                                        pNew.writes = randBelow(2) == 1;
                                end
                                3:
                                begin
                                        req = immFormReq(a);
                                        if (randBelow(2) == 1)
                                                pNew.dst = a;
                                end
                                4:
                                begin
                                        pOld.writes = 1'b0;
                                        pNew.writes = 1'b0;
                                        fwdEn = randBelow(2) == 1;
                                        ret.valid = 1'b1;
                                        ret.dst = (randBelow(2) == 1) ? a : b;
                                        ret.value = randWord();
                                        probeDue = 1'b1;
                                        probeDst = ret.dst;
                                end
                                5:
                                begin
                                        fwdEn = randBelow(2) == 1;
                                        if (randBelow(2) == 1)
                                                req = immFormReq(a);
                                end
                                default:
                                begin
                                        req = regFormReq(probeDst, probeDst);
                                        fwdEn = 1'b0;
                                        pOld.writes = 1'b0;
                                        pNew.writes = 1'b0;
                                        probeDue = 1'b0;
                                end
                        endcase
                        runTrans(req, pOld, pNew, fwdEn, ret, got);
                        if (kind == 6)
                        begin
                                checkWord(readShadow(probeDst), got.opA, "probe opA");
                                checkWord(readShadow(probeDst), got.opB, "probe opB");
                        end
                end

                $display("Finished with no errors");
                $finish;
        end

endmodule

/* all.f */
+incdir+sim
rtl/archPkg.sv
rtl/pipePkg.sv
rtl/issueIn.sv
rtl/regFile.sv
rtl/operandForward.sv
rtl/operandOut.sv
rtl/operandFetchTop.sv
sim/fetchTb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the operand fetch testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module fetchTb \
        -o fetchSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fetchSim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
